//--- Bender.yml
package:
  name: fds_mapper

sources:
  - fds_pkg.sv
  - fds_timer_irq.sv
  - fds_disk_port.sv
  - fds_bus_map.sv
  - fds_mapper.sv
  - target: test
    files:
      - fds_mapper_chk.sv
      - tb_fds_mapper.sv

//--- build.f
fds_pkg.sv
fds_timer_irq.sv
fds_disk_port.sv
fds_bus_map.sv
fds_mapper.sv
fds_mapper_chk.sv
tb_fds_mapper.sv

//--- fds_bus_map.sv
// FDS bus address map
`timescale 1ns/10ps
`default_nettype none

module fds_bus_map import fds_pkg::*; (
	input  wire addr_t     prg_ain,
	input  wire logic      prg_read,
	input  wire logic      prg_write,
	input  wire chr_addr_t chr_ain,
	input  wire data_t     prg_ram_din,
	input  wire logic      irq,
	input  wire logic      rd_active,
	input  wire logic      wr_active,
	input  wire logic      disk_end,
	input  wire logic      saved,
	input  wire logic      disk_eject,
	input  wire logic      vertical,
	input  wire rom_off_t  rom_offset,
	output mem_addr_t      prg_aout,
	output data_t          prg_dout,
	output logic           prg_allow,
	output mem_addr_t      chr_aout,
	output logic           chr_allow,
	output logic           vram_a10,
	output logic           vram_ce
);

	logic       seq_active;
	logic       port_lo;
	logic       port_hi;
	logic       wram_hit;
	logic       bios_hit;
	logic [5:0] prg_bank;
	logic [5:0] disk_bank;
	logic       mirror_a10;

	assign seq_active = rd_active | wr_active;

	// data port reads the pointer back unless a transfer is running
	assign port_lo = ((prg_ain == REG_READ_LO) || (prg_ain == REG_WRITE_LO)) && !seq_active;
	assign port_hi = ((prg_ain == REG_READ_HI) || (prg_ain == REG_WRITE_HI)) && !seq_active;

	// $6000-$DFFF and $E000-$FFFF
	assign wram_hit = (prg_ain[15:13] >= 3'd3) && (prg_ain[15:13] <= 3'd6);
	assign bios_hit = (prg_ain[15:13] == 3'd7);

	assign disk_bank = DISK_BANK_FLAG | {1'b0, rom_offset[17:13]};

	always_comb begin
		if (bios_hit)
			prg_bank = seq_active ? disk_bank : 6'd0;
		else
			prg_bank = WRAM_BANK_BASE + {4'd0, prg_ain[14:13]};
	end

	assign prg_aout = {PRG_REGION, prg_bank, prg_ain[12:0]};

	always_comb begin
		if (prg_ain == REG_IRQ_STATUS)
			prg_dout = {7'd0, irq};
		else if (prg_ain == REG_DRIVE_STATUS)
			prg_dout = {5'd0, disk_eject, disk_end, disk_eject};
		else if (prg_ain == REG_EXT_STATUS)
			prg_dout = EXT_STATUS_VAL;
		else if (port_lo)
			prg_dout = rom_offset[7:0];
		else if (port_hi)
			prg_dout = {3'b111, rom_offset[12:8]};
		else if (prg_ain == REG_SAVED)
			prg_dout = {7'd0, saved};
		else
			prg_dout = prg_ram_din;
	end

	// BIOS is read only and the disk takes writes only during a write sequence
	assign prg_allow = (prg_write && (wram_hit || wr_active))
		|| (prg_read && (wram_hit || bios_hit) && !port_lo && !port_hi);

	// $4025 bit 3 low selects vertical nametable mirroring
	assign mirror_a10 = vertical ? chr_ain[10] : chr_ain[11];

	assign chr_aout  = {CHR_REGION, 6'd0, chr_ain[12:11],
		(chr_ain[13] ? mirror_a10 : chr_ain[10]), chr_ain[9:0]};
	assign chr_allow = !chr_ain[13];
	assign vram_a10  = mirror_a10;
	assign vram_ce   = chr_ain[13];

endmodule

`default_nettype wire

//--- fds_disk_port.sv
// FDS disk data port
`timescale 1ns/10ps
`default_nettype none

module fds_disk_port import fds_pkg::*; (
	input  wire logic  clk20,
	input  wire logic  reset,
	input  wire logic  ce,
	input  wire addr_t prg_ain,
	input  wire logic  prg_read,
	input  wire logic  prg_write,
	input  wire data_t prg_din,
	input  wire logic  fds_swap,
	output logic       rd_active,
	output logic       wr_active,
	output logic       disk_end,
	output logic       saved,
	output logic       disk_eject,
	output logic       vertical,
	output rom_off_t   rom_offset
);

	seq_t      rd_state;
	seq_t      wr_state;
	disk_pos_t disk_pos;
	logic [1:0] side;
	rom_off_t  side_offset;
	logic      write_en;
	logic      disk_reset;
	logic [EJECT_CNT_W-1:0] eject_cnt;
	logic      rd_lo_hit;
	logic      rd_hi_hit;
	logic      wr_lo_hit;
	logic      wr_hi_hit;

	// LO starts a sequence, HI right after it completes it
	function automatic seq_t seq_next(input seq_t cur, input logic lo_hit,
		input logic hi_hit);
		if (lo_hit)
			return FIRST;
		else if (hi_hit && (cur == FIRST))
			return ACTIVE;
		return IDLE;
	endfunction

	assign rd_lo_hit = prg_read && (prg_ain == REG_READ_LO);
	assign rd_hi_hit = prg_read && (prg_ain == REG_READ_HI);
	assign wr_lo_hit = write_en && prg_read && (prg_ain == REG_WRITE_LO);
	assign wr_hi_hit = prg_read && (prg_ain == REG_WRITE_HI);

	assign rd_active = (rd_state == ACTIVE);
	assign wr_active = (wr_state == ACTIVE);
	assign disk_end  = (disk_pos == DISK_END_POS);

	// header plus whole sides ahead of the selected one
	assign side_offset = rom_off_t'(DISK_HEADER + int'(side) * SIDE_BYTES);
	assign rom_offset  = rom_off_t'(disk_pos) + side_offset;

	// drive reports a change of disk while the top bit is high
	assign disk_eject = eject_cnt[EJECT_CNT_W-1] | fds_swap;

	// $4025 and $4027
	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_reset <= 1'b0;
			write_en   <= 1'b0;
			vertical   <= 1'b0;
			side       <= 2'd0;
		end else if (ce && prg_write) begin
			if (prg_ain == REG_DISK_CTRL) begin
				disk_reset <= prg_din[1];
				write_en   <= !prg_din[2];
				vertical   <= !prg_din[3];
			end
			if (prg_ain == REG_DISK_SIDE)
				side <= prg_din[1:0];
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			rd_state  <= IDLE;
			wr_state  <= IDLE;
			disk_pos  <= '0;
			saved     <= 1'b0;
			eject_cnt <= '0;
		end else if (ce) begin
			rd_state  <= seq_next(rd_state, rd_lo_hit, rd_hi_hit);
			wr_state  <= seq_next(wr_state, wr_lo_hit, wr_hi_hit);
			eject_cnt <= eject_cnt + 1'b1;
			if (disk_reset)
				disk_pos <= '0;
			else if (rd_active && !disk_end)
				disk_pos <= disk_pos + 16'd1;
			// sticky until reset, polled at $4208
			if (wr_active)
				saved <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- fds_mapper.sv
// FDS mapper top level
`timescale 1ns/10ps
`default_nettype none

module fds_mapper import fds_pkg::*; (
	input  wire logic      clk20,
	input  wire logic      reset,
	input  wire logic      ce,
	input  wire addr_t     prg_ain,
	input  wire logic      prg_read,
	input  wire logic      prg_write,
	input  wire data_t     prg_din,
	input  wire data_t     prg_ram_din,
	input  wire chr_addr_t chr_ain,
	input  wire logic      fds_swap,
	output mem_addr_t      prg_aout,
	output data_t          prg_dout,
	output logic           prg_allow,
	output mem_addr_t      chr_aout,
	output logic           chr_allow,
	output logic           vram_a10,
	output logic           vram_ce,
	output logic           irq
);

	logic     rd_active;
	logic     wr_active;
	logic     disk_end;
	logic     saved;
	logic     disk_eject;
	logic     vertical;
	rom_off_t rom_offset;

	fds_timer_irq timer_i (
		.clk20, .reset, .ce, .prg_ain, .prg_write, .prg_read, .prg_din,
		.irq
	);

	fds_disk_port disk_i (
		.clk20, .reset, .ce, .prg_ain, .prg_read, .prg_write, .prg_din,
		.fds_swap,
		.rd_active, .wr_active, .disk_end, .saved, .disk_eject, .vertical,
		.rom_offset
	);

	// address and data paths are combinational
	fds_bus_map map_i (
		.prg_ain, .prg_read, .prg_write, .chr_ain, .prg_ram_din,
		.irq, .rd_active, .wr_active, .disk_end, .saved, .disk_eject,
		.vertical, .rom_offset,
		.prg_aout, .prg_dout, .prg_allow,
		.chr_aout, .chr_allow, .vram_a10, .vram_ce
	);

endmodule

`default_nettype wire

//--- fds_mapper_chk.sv
// FDS mapper bound checker
`timescale 1ns/10ps
`default_nettype none

module fds_mapper_chk import fds_pkg::*; (
	input wire logic      clk20,
	input wire logic      reset,
	input wire logic      ce,
	input wire addr_t     prg_ain,
	input wire logic      prg_read,
	input wire logic      prg_write,
	input wire data_t     prg_din,
	input wire chr_addr_t chr_ain,
	input wire mem_addr_t prg_aout,
	input wire logic      prg_allow,
	input wire data_t     prg_dout,
	input wire mem_addr_t chr_aout,
	input wire logic      vram_a10,
	input wire logic      vram_ce,
	input wire logic      chr_allow,
	input wire logic      irq,
	input wire logic      rd_active,
	input wire logic      wr_active,
	input wire logic      saved
);

	int   fail_count = 0;
	logic horiz;

	// high while $4025 bit 3 selects horizontal mirroring
	always_ff @(posedge clk20) begin
		if (reset)
			horiz <= 1'b1;
		else if (ce && prg_write && (prg_ain == REG_DISK_CTRL))
			horiz <= prg_din[3];
	end

	a_chr: assert property (@(posedge clk20) disable iff (reset)
		(vram_ce == chr_ain[13]) && (chr_allow == !chr_ain[13]))
	else begin
		$error("vram_ce or chr_allow does not follow chr_ain bit 13");
		fail_count++;
	end

	a_mirror: assert property (@(posedge clk20) disable iff (reset)
		vram_a10 == (horiz ? chr_ain[11] : chr_ain[10]))
	else begin
		$error("vram_a10 does not follow the selected mirroring");
		fail_count++;
	end

	// nametable fetches fold bit 10 onto the mirror bit
	a_chr_map: assert property (@(posedge clk20) disable iff (reset)
		(chr_aout[21:19] == CHR_REGION) && (chr_aout[18:13] == 6'd0)
		&& (chr_aout[12:11] == chr_ain[12:11]) && (chr_aout[9:0] == chr_ain[9:0])
		&& (chr_aout[10] == (chr_ain[13]
			? (horiz ? chr_ain[11] : chr_ain[10]) : chr_ain[10])))
	else begin
		$error("chr_aout does not map chr_ain into the CHR region");
		fail_count++;
	end

	// work RAM bank is the base plus address bits 14:13
	a_wram_map: assert property (@(posedge clk20) disable iff (reset)
		(prg_read || prg_write) && (prg_ain >= 16'h6000) && (prg_ain <= 16'hDFFF)
		|-> prg_allow
		&& (prg_aout == {PRG_REGION, WRAM_BANK_BASE + {4'd0, prg_ain[14:13]}, prg_ain[12:0]}))
	else begin
		$error("work RAM access mapped or allowed wrongly");
		fail_count++;
	end

	a_bios_idle: assert property (@(posedge clk20) disable iff (reset)
		prg_read && (prg_ain[15:13] == 3'd7) && !rd_active && !wr_active
		|-> prg_aout[18:13] == 6'd0)
	else begin
		$error("idle read at $E000-$FFFF left the BIOS bank");
		fail_count++;
	end

	a_disk_window: assert property (@(posedge clk20) disable iff (reset)
		(prg_ain[15:13] == 3'd7) && rd_active |-> prg_aout[18])
	else begin
		$error("active read sequence did not select the disk image");
		fail_count++;
	end

	a_bios_no_write: assert property (@(posedge clk20) disable iff (reset)
		prg_write && (prg_ain[15:13] == 3'd7) && !wr_active |-> !prg_allow)
	else begin
		$error("write to $E000-$FFFF allowed outside a write sequence");
		fail_count++;
	end

	// old flag is on the bus and clears one clock later
	a_irq_read: assert property (@(posedge clk20) disable iff (reset)
		ce && prg_read && (prg_ain == REG_IRQ_STATUS) && irq |-> prg_dout[0] ##1 !irq)
	else begin
		$error("irq status read did not show or clear the flag");
		fail_count++;
	end

	a_saved_set: assert property (@(posedge clk20) disable iff (reset)
		ce && wr_active |=> saved)
	else begin
		$error("saved flag did not set during a write sequence");
		fail_count++;
	end

endmodule

bind fds_mapper fds_mapper_chk chk_i (
	.clk20, .reset, .ce, .prg_ain, .prg_read, .prg_write, .prg_din,
	.chr_ain, .prg_aout, .prg_allow, .prg_dout, .chr_aout, .vram_a10, .vram_ce,
	.chr_allow, .irq, .rd_active, .wr_active, .saved
);

`default_nettype wire

//--- fds_pkg.sv
// FDS mapper shared definitions
`default_nettype none

package fds_pkg;

	// bus and memory types
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [21:0] mem_addr_t;
	typedef logic [13:0] chr_addr_t;
	typedef logic [15:0] disk_pos_t;
	typedef logic [17:0] rom_off_t;

	// timer registers
	localparam addr_t REG_TIMER_LO     = 16'h4020;
	localparam addr_t REG_TIMER_HI     = 16'h4021;
	localparam addr_t REG_TIMER_CTRL   = 16'h4022;

	// disk control and side select
	localparam addr_t REG_DISK_CTRL    = 16'h4025;
	localparam addr_t REG_DISK_SIDE    = 16'h4027;

	// status readback
	localparam addr_t REG_IRQ_STATUS   = 16'h4030;
	localparam addr_t REG_DRIVE_STATUS = 16'h4032;
	localparam addr_t REG_EXT_STATUS   = 16'h4033;
	localparam addr_t REG_SAVED        = 16'h4208;

	// disk data port hit by the patched BIOS
	localparam addr_t REG_WRITE_LO     = 16'hF4CD;
	localparam addr_t REG_WRITE_HI     = 16'hF4CE;
	localparam addr_t REG_READ_LO      = 16'hF4D0;
	localparam addr_t REG_READ_HI      = 16'hF4D1;

	// disk image layout
	localparam int SIDE_BYTES  = 65500;
	localparam int DISK_HEADER = 16;
	localparam disk_pos_t DISK_END_POS = 16'd65499;

	// eject toggle follows the top bit of this counter
	localparam int EJECT_CNT_W = 22;

	localparam data_t EXT_STATUS_VAL = 8'h80;

	// bits 21:19 of the memory address pick the region
	localparam logic [2:0] CHR_REGION = 3'h4;
	localparam logic [2:0] PRG_REGION = 3'h0;

	// PRG bank field covers bits 18:13
	localparam logic [5:0] WRAM_BANK_BASE = 6'h04;
	// bank bit 5 is address bit 18 and selects the disk image half
	localparam logic [5:0] DISK_BANK_FLAG = 6'h20;

	// data port sequence tracker
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		FIRST  = 2'd1,
		ACTIVE = 2'd2
	} seq_t;

endpackage

`default_nettype wire

//--- fds_timer_irq.sv
// FDS timer IRQ
`timescale 1ns/10ps
`default_nettype none

module fds_timer_irq import fds_pkg::*; (
	input  wire logic  clk20,
	input  wire logic  reset,
	input  wire logic  ce,
	input  wire addr_t prg_ain,
	input  wire logic  prg_write,
	input  wire logic  prg_read,
	input  wire data_t prg_din,
	output logic       irq
);

	logic [15:0] timer_latch;
	logic [15:0] timer_cnt;
	logic        timer_en;
	logic        timer_repeat;
	logic        ctrl_wr;
	logic        status_rd;
	logic        timer_trip;

	assign ctrl_wr    = ce && prg_write && (prg_ain == REG_TIMER_CTRL);
	assign status_rd  = ce && prg_read && (prg_ain == REG_IRQ_STATUS);
	// counter at 1 on an enabled cycle fires the irq
	assign timer_trip = ce && timer_en && (timer_cnt == 16'd1);

	// reload latch loaded a byte at a time
	always_ff @(posedge clk20) begin
		if (ce && prg_write && (prg_ain == REG_TIMER_LO))
			timer_latch[7:0] <= prg_din;
		if (ce && prg_write && (prg_ain == REG_TIMER_HI))
			timer_latch[15:8] <= prg_din;
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
			timer_cnt    <= '0;
			irq          <= 1'b0;
		end else begin
			if (ctrl_wr) begin
				timer_repeat <= prg_din[0];
				timer_en     <= prg_din[1];
			end
			// load on control write or on repeat trip
			if (ctrl_wr || (timer_trip && timer_repeat))
				timer_cnt <= timer_latch;
			else if (ce && timer_en && (timer_cnt != 16'd0))
				timer_cnt <= timer_cnt - 16'd1;
			// status read wins over a trip in the same cycle
			if (status_rd)
				irq <= 1'b0;
			else if (timer_trip)
				irq <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- tb_fds_mapper.sv
// FDS mapper testbench
`timescale 1ns/10ps
`default_nettype none

module tb_fds_mapper
	import fds_pkg::*;
();

	logic      clk20;
	logic      reset;
	logic      ce;
	addr_t     prg_ain;
	logic      prg_read;
	logic      prg_write;
	data_t     prg_din;
	data_t     prg_ram_din;
	chr_addr_t chr_ain;
	logic      fds_swap;
	mem_addr_t prg_aout;
	data_t     prg_dout;
	logic      prg_allow;
	mem_addr_t chr_aout;
	logic      chr_allow;
	logic      vram_a10;
	logic      vram_ce;
	logic      irq;

	integer      seed;
	int          err_count;
	int          timeout_count;
	int          total;
	data_t       rd_data;
	mem_addr_t   last_aout;
	logic        last_allow;
	addr_t       addr;
	int unsigned n;
	int          count;
	int          side;
	int          base;
	int          off;
	int          k;

	fds_mapper dut_i (
		.clk20, .reset, .ce, .prg_ain, .prg_read, .prg_write, .prg_din,
		.prg_ram_din, .chr_ain, .fds_swap,
		.prg_aout, .prg_dout, .prg_allow, .chr_aout, .chr_allow,
		.vram_a10, .vram_ce, .irq
	);

	always #2 clk20 = !clk20;

	// one CPU cycle with outputs captured mid-cycle
	task automatic bus_cycle(input addr_t a, input logic rd, input data_t d);
		@(posedge clk20);
		ce          <= 1'b1;
		prg_read    <= rd;
		prg_write   <= !rd;
		prg_ain     <= a;
		prg_din     <= d;
		// memory model returns the low address byte
		prg_ram_din <= a[7:0];
		@(negedge clk20);
		rd_data    = prg_dout;
		last_aout  = prg_aout;
		last_allow = prg_allow;
		@(posedge clk20);
		ce        <= 1'b0;
		prg_read  <= 1'b0;
		prg_write <= 1'b0;
	endtask

	task automatic cpu_write(input addr_t a, input data_t d);
		bus_cycle(a, 1'b0, d);
	endtask

	task automatic cpu_read(input addr_t a);
		bus_cycle(a, 1'b1, 8'h00);
	endtask

	// a ce cycle with no bus access
	task automatic idle_tick();
		@(posedge clk20);
		ce <= 1'b1;
		@(posedge clk20);
		ce <= 1'b0;
	endtask

	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	initial begin
		clk20         = 1'b0;
		reset         = 1'b1;
		ce            = 1'b0;
		prg_ain       = '0;
		prg_read      = 1'b0;
		prg_write     = 1'b0;
		prg_din       = '0;
		prg_ram_din   = '0;
		chr_ain       = '0;
		fds_swap      = 1'b0;
		seed          = 32'hf51f;
		err_count     = 0;
		timeout_count = 0;
		repeat (10) @(posedge clk20);
		reset <= 1'b0;

		// one-shot timer irq
		n = 2 + ($unsigned($random(seed)) % 39);
		cpu_write(REG_TIMER_LO, n[7:0]);
		cpu_write(REG_TIMER_HI, 8'h00);
		cpu_write(REG_TIMER_CTRL, 8'h02);
		@(negedge clk20);
		count = 0;
		while (!irq && (count <= n + 1)) begin
			idle_tick();
			@(negedge clk20);
			count++;
		end
		if (!irq) begin
			timeout_count++;
			$display("timeout: timer irq did not rise within %0d ce cycles", n + 1);
		end else if ((count < n - 1) || (count > n + 1)) begin
			err_count++;
			$display("ERR %0t irq rise got %0d cycles expected %0d to %0d",
				$time, count, n - 1, n + 1);
		end
		cpu_read(REG_IRQ_STATUS);
		compare("prg_dout[0]", rd_data[0], 1);
		@(negedge clk20);
		compare("irq", irq, 0);
		cpu_write(REG_TIMER_CTRL, 8'h00);

		// work RAM accesses
		repeat (12) begin
			addr = 16'h6000 + 16'($unsigned($random(seed)) % 32'h8000);
			if ($random(seed) & 1) begin
				cpu_read(addr);
				compare("prg_dout", rd_data, addr[7:0]);
			end else begin
				cpu_write(addr, 8'($random(seed)));
			end
		end
		addr = 16'hE000 + 16'($unsigned($random(seed)) % 32'h1000);
		cpu_read(addr);
		compare("prg_dout", rd_data, addr[7:0]);

		// pointer to zero and a random side
		cpu_write(REG_DISK_CTRL, 8'h02);
		cpu_write(REG_DISK_CTRL, 8'h00);
		side = $unsigned($random(seed)) % 4;
		cpu_write(REG_DISK_SIDE, 8'(side));
		base = 16 + side * 65500;
		cpu_read(REG_READ_LO);
		compare("disk_offset_lo", rd_data, base[7:0]);
		k = 1 + ($unsigned($random(seed)) % 6);
		for (int i = 0; i < k; i++) begin
			off = base + i;
			cpu_read(REG_READ_LO);
			compare("disk_offset_lo", rd_data, off[7:0]);
			cpu_read(REG_READ_HI);
			compare("disk_offset_hi", rd_data, {3'b111, off[12:8]});
			// this read advances the pointer
			addr = 16'hE000 + 16'($unsigned($random(seed)) % 32'h1000);
			cpu_read(addr);
			compare("prg_aout[17:13]", last_aout[17:13], off[17:13]);
		end
		off = base + k;
		cpu_read(REG_READ_LO);
		compare("disk_offset_lo", rd_data, off[7:0]);

		// write sequence with write_en still set
		cpu_read(REG_SAVED);
		compare("saved", rd_data[0], 0);
		cpu_read(REG_WRITE_LO);
		cpu_read(REG_WRITE_HI);
		cpu_write(16'hE000, 8'h5a);
		compare("prg_allow", last_allow, 1);
		cpu_read(REG_SAVED);
		compare("saved", rd_data[0], 1);
		cpu_write(16'hE000, 8'ha5);
		compare("prg_allow", last_allow, 0);

		// nametable mirroring under both settings of $4025 bit 3
		for (int b = 0; b < 2; b++) begin
			cpu_write(REG_DISK_CTRL, b ? 8'h08 : 8'h00);
			repeat (8) begin
				@(posedge clk20);
				chr_ain <= 14'($random(seed));
			end
		end

		// drive status
		cpu_read(REG_EXT_STATUS);
		compare("ext_status", rd_data, 8'h80);
		@(posedge clk20);
		fds_swap <= 1'b1;
		cpu_read(REG_DRIVE_STATUS);
		compare("drive_status", rd_data, 8'h05);
		@(posedge clk20);
		fds_swap <= 1'b0;
		cpu_read(REG_DRIVE_STATUS);
		compare("drive_status", rd_data, 8'h00);

		repeat (4) @(posedge clk20);
		total = err_count + timeout_count + dut_i.chk_i.fail_count;
		$display("checks done: %0d assertion failures, %0d value errors, %0d timeouts",
			dut_i.chk_i.fail_count, err_count, timeout_count);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
